/* design/ctlPkg.sv */
package ctlPkg;

  // Microword field widths
  typedef logic [2:0] dispT;
  typedef logic [2:0] specT;
  typedef logic [2:0] condT;
  typedef logic [1:0] arSelT;
  typedef logic [8:0] magicT;

  // Bits 24:23 spare, then disp, spec, cond, arSel, arxSel, mqLoad, magic
  typedef logic [24:0] uinstT;

  // Console function code and diagnostic register
  typedef logic [6:0] diagFuncT;
  typedef logic [3:0] diagRegT;

  localparam dispT dispNone   = 3'd0;
  localparam dispT dispMul    = 3'd1;
  localparam dispT dispNorm   = 3'd2;
  localparam dispT dispEaMod  = 3'd3;

  localparam specT specNone     = 3'd0;
  localparam specT specInhCry18 = 3'd1;
  localparam specT specGenCry18 = 3'd2;
  localparam specT specMqShift  = 3'd3;
  localparam specT specLoadPc   = 3'd4;
  localparam specT specArlInd   = 3'd5;

  // Codes 6 and 7 are no-ops
  localparam condT condNone    = 3'd0;
  localparam condT condArlLoad = 3'd1;
  localparam condT condArrLoad = 3'd2;
  localparam condT condArClr   = 3'd3;
  localparam condT condArxClr  = 3'd4;
  localparam condT condArlInd  = 3'd5;

  localparam arSelT selHold = 2'd0;
  localparam arSelT selMem  = 2'd1;
  localparam arSelT selAd   = 2'd2;
  localparam arSelT selAlt  = 2'd3;

  localparam diagFuncT diagLoadReg = 7'o076;
  localparam diagFuncT diagReadAr  = 7'o100;
  localparam diagFuncT diagReadArx = 7'o101;
  localparam diagFuncT diagReadMq  = 7'o102;
  localparam diagFuncT diagReadPc  = 7'o103;
  localparam diagFuncT diagReadCtl = 7'o104;
  localparam diagFuncT diagReadReg = 7'o105;
  localparam diagFuncT diagLoadAr  = 7'o177;

endpackage

/* design/uinstIssue.sv */
`timescale 1ns/1ps

module uinstIssue (
  input  logic          CTL,
  input  logic          rstN,
  input  logic          uReq,
  input  ctlPkg::uinstT uinst,
  output logic          uAck,
  output logic          step,
  output ctlPkg::uinstT heldUinst
);

  logic accept;

  // New request, not yet stepped or acknowledged
  assign accept = uReq && !uAck && !step;

  always_ff @(posedge CTL) begin
    if (!rstN) begin
      step <= 1'b0;
      uAck <= 1'b0;
    end else begin
      step <= accept;
      if (step) begin
        uAck <= 1'b1;
      end else if (!uReq) begin
        uAck <= 1'b0;
      end
    end
  end

  always_ff @(posedge CTL) begin
    if (accept) begin
      heldUinst <= uinst;
    end
  end

  // Ack only ever answers a live request
  assert property (@(posedge CTL) disable iff (!rstN)
    $rose(uAck) |-> $past(uReq))
    else $error("uAck rose without uReq");

endmodule

/* design/uinstDecode.sv */
`timescale 1ns/1ps

module uinstDecode (
  input  ctlPkg::uinstT  heldUinst,
  input  logic           step,
  input  logic           arx18,
  output ctlPkg::arSelT  arlSrc,
  output ctlPkg::arSelT  arrSrc,
  output ctlPkg::arSelT  arxSrc,
  output logic           arlClr,
  output logic           arrClr,
  output logic           arxClr,
  output logic           mqLoad,
  output logic           mqShift,
  output logic           mqClr,
  output logic           pcLoad,
  output logic           inhCry18,
  output logic           genCry18,
  output logic [8:0]     ctlStatus
);

  ctlPkg::dispT  disp;
  ctlPkg::specT  spec;
  ctlPkg::condT  cond;
  ctlPkg::arSelT arSel;
  ctlPkg::arSelT arxSel;
  ctlPkg::magicT magic;
  logic          arlInd;

  // Field split of the held microword
  assign disp   = heldUinst[22:20];
  assign spec   = heldUinst[19:17];
  assign cond   = heldUinst[16:14];
  assign arSel  = heldUinst[13:12];
  assign arxSel = heldUinst[11:10];
  assign magic  = heldUinst[8:0];

  always_comb begin
    arlInd   = step && (spec == ctlPkg::specArlInd || cond == ctlPkg::condArlInd);
    // Short EA from ARX bit 18, top of the right half
    arlClr   = step && (cond == ctlPkg::condArClr || (disp == ctlPkg::dispEaMod && arx18));
    arrClr   = step && (cond == ctlPkg::condArClr || (arlInd && magic[5]));
    arxClr   = step && cond == ctlPkg::condArxClr;
    mqClr    = arlInd && magic[6];
    mqShift  = step && (disp == ctlPkg::dispMul || disp == ctlPkg::dispNorm ||
                        spec == ctlPkg::specMqShift);
    mqLoad   = step && heldUinst[9];
    pcLoad   = step && spec == ctlPkg::specLoadPc;
    inhCry18 = step && spec == ctlPkg::specInhCry18;
    genCry18 = step && spec == ctlPkg::specGenCry18;

    arlSrc = ctlPkg::selHold;
    arrSrc = ctlPkg::selHold;
    arxSrc = ctlPkg::selHold;
    if (step) begin
      if (arlInd) begin
        arlSrc = magic[8:7];
      end else if (cond != ctlPkg::condArrLoad) begin
        arlSrc = arSel;
      end
      if (cond != ctlPkg::condArlLoad) begin
        arrSrc = arSel;
      end
      arxSrc = arxSel;
    end

    // Clear wins over any load
    if (arlClr) arlSrc = ctlPkg::selHold;
    if (arrClr) arrSrc = ctlPkg::selHold;
    if (arxClr) arxSrc = ctlPkg::selHold;
  end

  assign ctlStatus = {arlClr, arrClr, arxClr, mqShift, mqClr,
                      pcLoad, inhCry18, genCry18, arlInd};

endmodule

/* design/arDatapath.sv */
`timescale 1ns/1ps

module arDatapath #(
  parameter int dataWidth = 36
) (
  input  logic                   CTL,
  input  logic                   rstN,
  input  ctlPkg::arSelT          arlSrc,
  input  ctlPkg::arSelT          arrSrc,
  input  ctlPkg::arSelT          arxSrc,
  input  logic                   arlClr,
  input  logic                   arrClr,
  input  logic                   arxClr,
  input  logic                   mqLoad,
  input  logic                   mqShift,
  input  logic                   mqClr,
  input  logic                   pcLoad,
  input  logic                   inhCry18,
  input  logic                   genCry18,
  input  logic [dataWidth-1:0]   memData,
  input  logic                   arWrite,
  input  logic [dataWidth-1:0]   arWriteData,
  output logic [dataWidth-1:0]   ar,
  output logic [dataWidth-1:0]   arx,
  output logic [dataWidth-1:0]   mq,
  output logic [dataWidth/2-1:0] pc,
  output logic                   arx18
);

  localparam int halfWidth = dataWidth / 2;

  logic [halfWidth:0]   rightSum;
  logic [halfWidth-1:0] leftSum;
  logic                 cry18;
  logic [halfWidth-1:0] arlNext;
  logic [halfWidth-1:0] arrNext;
  logic [dataWidth-1:0] arxNext;
  logic [dataWidth-1:0] mqNext;

  function automatic logic [halfWidth-1:0] pickHalf(
    input ctlPkg::arSelT        sel,
    input logic [halfWidth-1:0] mem,
    input logic [halfWidth-1:0] ad,
    input logic [halfWidth-1:0] alt,
    input logic [halfWidth-1:0] cur
  );
    case (sel)
      ctlPkg::selMem: return mem;
      ctlPkg::selAd:  return ad;
      ctlPkg::selAlt: return alt;
      default:        return cur;
    endcase
  endfunction

  always_comb begin
    rightSum = {1'b0, ar[halfWidth-1:0]} + {1'b0, arx[halfWidth-1:0]};
    // Carry into the left half can be cut or forced
    cry18    = genCry18 || (rightSum[halfWidth] && !inhCry18);
    leftSum  = ar[dataWidth-1:halfWidth] + arx[dataWidth-1:halfWidth] + halfWidth'(cry18);

    arlNext = arlClr ? '0 : pickHalf(arlSrc, memData[dataWidth-1:halfWidth], leftSum,
                                     arx[dataWidth-1:halfWidth], ar[dataWidth-1:halfWidth]);
    arrNext = arrClr ? '0 : pickHalf(arrSrc, memData[halfWidth-1:0], rightSum[halfWidth-1:0],
                                     arx[halfWidth-1:0], ar[halfWidth-1:0]);

    case (arxSrc)
      ctlPkg::selMem: arxNext = memData;
      ctlPkg::selAd:  arxNext = ar;
      ctlPkg::selAlt: arxNext = mq;
      default:        arxNext = arx;
    endcase
    if (arxClr) arxNext = '0;

    if (mqClr) mqNext = '0;
    else if (mqShift) mqNext = {mq[dataWidth-2:0], ar[dataWidth-1]};
    else if (mqLoad) mqNext = arx;
    else mqNext = mq;
  end

  always_ff @(posedge CTL) begin
    if (!rstN) begin
      ar  <= '0;
      arx <= '0;
      mq  <= '0;
      pc  <= '0;
    end else begin
      // Console write takes AR over a coinciding step
      ar  <= arWrite ? arWriteData : {arlNext, arrNext};
      arx <= arxNext;
      mq  <= mqNext;
      if (pcLoad) pc <= ar[halfWidth-1:0];
    end
  end

  assign arx18 = arx[halfWidth-1];

endmodule

/* design/diagResult.sv */
`timescale 1ns/1ps

module diagResult #(
  parameter int dataWidth = 36
) (
  input  logic                   CTL,
  input  logic                   rstN,
  input  logic                   dReq,
  input  ctlPkg::diagFuncT       diagFunc,
  input  logic [dataWidth-1:0]   diagData,
  input  logic [dataWidth-1:0]   ar,
  input  logic [dataWidth-1:0]   arx,
  input  logic [dataWidth-1:0]   mq,
  input  logic [dataWidth/2-1:0] pc,
  input  logic [8:0]             ctlStatus,
  output logic                   dAck,
  output logic [dataWidth-1:0]   readData,
  output logic                   arWrite,
  output logic [dataWidth-1:0]   arWriteData,
  output logic                   memReset,
  output logic                   channelClkStop
);

  ctlPkg::diagRegT      diagReg;
  logic [3:0]           group;
  logic [2:0]           digit;
  logic                 accept;
  logic                 isLoadReg;
  logic                 isLoadAr;
  logic [dataWidth-1:0] readMux;

  // Group is the top octal digits, then the low digit picks the function
  assign group     = diagFunc[6:3];
  assign digit     = diagFunc[2:0];
  assign isLoadReg = group == ctlPkg::diagLoadReg[6:3] && digit == ctlPkg::diagLoadReg[2:0];
  assign isLoadAr  = group == ctlPkg::diagLoadAr[6:3] && digit == ctlPkg::diagLoadAr[2:0];
  assign accept    = dReq && !dAck;

  always_comb begin
    readMux = '0;
    if (group == ctlPkg::diagReadAr[6:3]) begin
      case (digit)
        ctlPkg::diagReadAr[2:0]:  readMux = ar;
        ctlPkg::diagReadArx[2:0]: readMux = arx;
        ctlPkg::diagReadMq[2:0]:  readMux = mq;
        ctlPkg::diagReadPc[2:0]:  readMux = dataWidth'(pc);
        ctlPkg::diagReadCtl[2:0]: readMux = dataWidth'(ctlStatus);
        ctlPkg::diagReadReg[2:0]: readMux = dataWidth'(diagReg);
        default:                  readMux = '0;
      endcase
    end
  end

  always_ff @(posedge CTL) begin
    if (!rstN) begin
      dAck     <= 1'b0;
      readData <= '0;
      arWrite  <= 1'b0;
      diagReg  <= '0;
    end else begin
      arWrite <= accept && isLoadAr;
      if (accept) begin
        dAck     <= 1'b1;
        readData <= readMux;
        if (isLoadReg) diagReg <= diagData[3:0];
      end else if (!dReq) begin
        dAck     <= 1'b0;
        readData <= '0;
      end
    end
  end

  always_ff @(posedge CTL) begin
    if (accept) arWriteData <= diagData;
  end

  // memReset, channelClkStop, ldEbusReg, forceExtend
  assign memReset       = diagReg[3];
  assign channelClkStop = diagReg[2];

  assert property (@(posedge CTL) disable iff (!rstN) arWrite |=> !arWrite)
    else $error("arWrite held past one cycle");

endmodule

/* design/ctlSubsystem.sv */
`timescale 1ns/1ps

module ctlSubsystem #(
  parameter int dataWidth = 36
) (
  input  logic                 CTL,
  input  logic                 rstN,
  input  logic                 uReq,
  input  ctlPkg::uinstT        uinst,
  output logic                 uAck,
  input  logic [dataWidth-1:0] memData,
  input  logic                 dReq,
  input  ctlPkg::diagFuncT     diagFunc,
  input  logic [dataWidth-1:0] diagData,
  output logic                 dAck,
  output logic [dataWidth-1:0] readData,
  output logic                 memReset,
  output logic                 channelClkStop
);

  logic                   step;
  ctlPkg::uinstT          heldUinst;
  ctlPkg::arSelT          arlSrc;
  ctlPkg::arSelT          arrSrc;
  ctlPkg::arSelT          arxSrc;
  logic                   arlClr;
  logic                   arrClr;
  logic                   arxClr;
  logic                   mqLoad;
  logic                   mqShift;
  logic                   mqClr;
  logic                   pcLoad;
  logic                   inhCry18;
  logic                   genCry18;
  logic [8:0]             ctlStatus;
  logic [dataWidth-1:0]   ar;
  logic [dataWidth-1:0]   arx;
  logic [dataWidth-1:0]   mq;
  logic [dataWidth/2-1:0] pc;
  logic                   arx18;
  logic                   arWrite;
  logic [dataWidth-1:0]   arWriteData;

  uinstIssue uinstIssue_inst (
    .CTL       (CTL),
    .rstN      (rstN),
    .uReq      (uReq),
    .uinst     (uinst),
    .uAck      (uAck),
    .step      (step),
    .heldUinst (heldUinst)
  );

  uinstDecode uinstDecode_inst (
    .heldUinst (heldUinst),
    .step      (step),
    .arx18     (arx18),
    .arlSrc    (arlSrc),
    .arrSrc    (arrSrc),
    .arxSrc    (arxSrc),
    .arlClr    (arlClr),
    .arrClr    (arrClr),
    .arxClr    (arxClr),
    .mqLoad    (mqLoad),
    .mqShift   (mqShift),
    .mqClr     (mqClr),
    .pcLoad    (pcLoad),
    .inhCry18  (inhCry18),
    .genCry18  (genCry18),
    .ctlStatus (ctlStatus)
  );

  arDatapath #(.dataWidth(dataWidth)) arDatapath_inst (
    .CTL         (CTL),
    .rstN        (rstN),
    .arlSrc      (arlSrc),
    .arrSrc      (arrSrc),
    .arxSrc      (arxSrc),
    .arlClr      (arlClr),
    .arrClr      (arrClr),
    .arxClr      (arxClr),
    .mqLoad      (mqLoad),
    .mqShift     (mqShift),
    .mqClr       (mqClr),
    .pcLoad      (pcLoad),
    .inhCry18    (inhCry18),
    .genCry18    (genCry18),
    .memData     (memData),
    .arWrite     (arWrite),
    .arWriteData (arWriteData),
    .ar          (ar),
    .arx         (arx),
    .mq          (mq),
    .pc          (pc),
    .arx18       (arx18)
  );

  diagResult #(.dataWidth(dataWidth)) diagResult_inst (
    .CTL            (CTL),
    .rstN           (rstN),
    .dReq           (dReq),
    .diagFunc       (diagFunc),
    .diagData       (diagData),
    .ar             (ar),
    .arx            (arx),
    .mq             (mq),
    .pc             (pc),
    .ctlStatus      (ctlStatus),
    .dAck           (dAck),
    .readData       (readData),
    .arWrite        (arWrite),
    .arWriteData    (arWriteData),
    .memReset       (memReset),
    .channelClkStop (channelClkStop)
  );

endmodule

/* testbench/ctlSubsystemTb.sv */
`timescale 1ns/1ps

module ctlSubsystemTb;

  localparam int dataWidth = 36;
  localparam int halfWidth = dataWidth / 2;
  localparam int ackLimit  = 10;

  logic                 CTL;
  logic                 rstN;
  logic                 uReq;
  ctlPkg::uinstT        uinst;
  logic                 uAck;
  logic [dataWidth-1:0] memData;
  logic                 dReq;
  ctlPkg::diagFuncT     diagFunc;
  logic [dataWidth-1:0] diagData;
  logic                 dAck;
  logic [dataWidth-1:0] readData;
  logic                 memReset;
  logic                 channelClkStop;

  // Operations as read from the stimulus file
  logic [7:0]           opKind[$];
  ctlPkg::uinstT        opWord[$];
  logic [dataWidth-1:0] opData[$];
  logic [dataWidth-1:0] opExpect[$];
  logic [1:0]           opFlag[$];
  logic                 opsLoaded;

  // Reference model of the registers
  logic [dataWidth-1:0] mAr;
  logic [dataWidth-1:0] mArx;
  logic [dataWidth-1:0] mMq;
  logic [halfWidth-1:0] mPc;
  ctlPkg::diagRegT      mReg;

  int                   valueErrors;
  int                   otherErrors;
  logic                 aborted;
  integer               seed;

  ctlSubsystem #(.dataWidth(dataWidth)) ctlSubsystem_inst (
    .CTL            (CTL),
    .rstN           (rstN),
    .uReq           (uReq),
    .uinst          (uinst),
    .uAck           (uAck),
    .memData        (memData),
    .dReq           (dReq),
    .diagFunc       (diagFunc),
    .diagData       (diagData),
    .dAck           (dAck),
    .readData       (readData),
    .memReset       (memReset),
    .channelClkStop (channelClkStop)
  );

  initial begin
    CTL = 1'b0;
    forever #4 CTL = ~CTL;
  end

  task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
                            input logic [dataWidth-1:0] actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic nextCycle;
    @(posedge CTL);
    #1;
  endtask

  task automatic finishRun;
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic readStimulus;
    int                   fd;
    int                   n;
    logic [7:0]           kind;
    logic [8*160-1:0]     lineBuf;
    ctlPkg::dispT         disp;
    ctlPkg::specT         spec;
    ctlPkg::condT         cond;
    ctlPkg::arSelT        arSel;
    ctlPkg::arSelT        arxSel;
    logic                 mqLd;
    ctlPkg::magicT        magic;
    ctlPkg::diagFuncT     func;
    logic [dataWidth-1:0] value;
    logic [dataWidth-1:0] expectVal;
    logic [1:0]           flag;
    fd = $fopen("testbench/stimulus_input.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open testbench/stimulus_input.txt");
      otherErrors++;
    end else begin
      n = $fscanf(fd, " %c", kind);
      while (n == 1) begin
        if (kind == "#") begin
          n = $fgets(lineBuf, fd);
        end else if (kind == "U") begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", disp, spec, cond, arSel, arxSel,
                      mqLd, magic, value, flag);
          if (n == 9) begin
            opKind.push_back(kind);
            opWord.push_back({2'b00, disp, spec, cond, arSel, arxSel, mqLd, magic});
            opData.push_back(value);
            opExpect.push_back('0);
            opFlag.push_back(flag);
          end else begin
            $display("Error: malformed microword line in stimulus file");
            otherErrors++;
          end
        end else if (kind == "D") begin
          n = $fscanf(fd, "%o %h %h %h", func, value, expectVal, flag);
          if (n == 4) begin
            opKind.push_back(kind);
            opWord.push_back({18'd0, func});
            opData.push_back(value);
            opExpect.push_back(expectVal);
            opFlag.push_back(flag);
          end else begin
            $display("Error: malformed console line in stimulus file");
            otherErrors++;
          end
        end else begin
          $display("Error: unknown operation kind in stimulus file");
          otherErrors++;
        end
        n = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
    end
    opsLoaded = 1'b1;
  endtask

  // Applies one microword to the model, returns the expected strobe snapshot
  task automatic predictStep(input ctlPkg::uinstT word, input logic [dataWidth-1:0] mem,
                             output logic [8:0] status);
    ctlPkg::dispT         disp;
    ctlPkg::specT         spec;
    ctlPkg::condT         cond;
    ctlPkg::arSelT        arSel;
    ctlPkg::arSelT        arxSel;
    ctlPkg::arSelT        lSel;
    ctlPkg::arSelT        rSel;
    ctlPkg::magicT        magic;
    logic                 mqLd;
    logic                 ind;
    logic                 lClr;
    logic                 rClr;
    logic                 xClr;
    logic                 qClr;
    logic                 qShift;
    logic                 pLoad;
    logic                 inh;
    logic                 gen;
    logic                 carry;
    logic [halfWidth:0]   rSum;
    logic [halfWidth-1:0] lSum;
    logic [halfWidth-1:0] newL;
    logic [halfWidth-1:0] newR;
    logic [dataWidth-1:0] newX;
    logic [dataWidth-1:0] newQ;
    disp   = word[22:20];
    spec   = word[19:17];
    cond   = word[16:14];
    arSel  = word[13:12];
    arxSel = word[11:10];
    mqLd   = word[9];
    magic  = word[8:0];

    ind    = spec == ctlPkg::specArlInd || cond == ctlPkg::condArlInd;
    lClr   = cond == ctlPkg::condArClr || (disp == ctlPkg::dispEaMod && mArx[halfWidth-1]);
    rClr   = cond == ctlPkg::condArClr || (ind && magic[5]);
    xClr   = cond == ctlPkg::condArxClr;
    qClr   = ind && magic[6];
    qShift = disp == ctlPkg::dispMul || disp == ctlPkg::dispNorm ||
             spec == ctlPkg::specMqShift;
    pLoad  = spec == ctlPkg::specLoadPc;
    inh    = spec == ctlPkg::specInhCry18;
    gen    = spec == ctlPkg::specGenCry18;

    if (ind) lSel = magic[8:7];
    else if (cond == ctlPkg::condArrLoad) lSel = ctlPkg::selHold;
    else lSel = arSel;
    rSel = (cond == ctlPkg::condArlLoad) ? ctlPkg::selHold : arSel;

    rSum  = {1'b0, mAr[halfWidth-1:0]} + {1'b0, mArx[halfWidth-1:0]};
    carry = gen || (rSum[halfWidth] && !inh);
    lSum  = mAr[dataWidth-1:halfWidth] + mArx[dataWidth-1:halfWidth] + halfWidth'(carry);

    case (lSel)
      ctlPkg::selMem: newL = mem[dataWidth-1:halfWidth];
      ctlPkg::selAd:  newL = lSum;
      ctlPkg::selAlt: newL = mArx[dataWidth-1:halfWidth];
      default:        newL = mAr[dataWidth-1:halfWidth];
    endcase
    if (lClr) newL = '0;
    case (rSel)
      ctlPkg::selMem: newR = mem[halfWidth-1:0];
      ctlPkg::selAd:  newR = rSum[halfWidth-1:0];
      ctlPkg::selAlt: newR = mArx[halfWidth-1:0];
      default:        newR = mAr[halfWidth-1:0];
    endcase
    if (rClr) newR = '0;
    case (arxSel)
      ctlPkg::selMem: newX = mem;
      ctlPkg::selAd:  newX = mAr;
      ctlPkg::selAlt: newX = mMq;
      default:        newX = mArx;
    endcase
    if (xClr) newX = '0;

    if (qClr) newQ = '0;
    else if (qShift) newQ = {mMq[dataWidth-2:0], mAr[dataWidth-1]};
    else if (mqLd) newQ = mArx;
    else newQ = mMq;

    // PC sees AR from before the step
    if (pLoad) mPc = mAr[halfWidth-1:0];
    mAr    = {newL, newR};
    mArx   = newX;
    mMq    = newQ;
    status = {lClr, rClr, xClr, qShift, qClr, pLoad, inh, gen, ind};
  endtask

  function automatic logic [dataWidth-1:0] expectedRead(input ctlPkg::diagFuncT func);
    case (func)
      ctlPkg::diagReadAr:  return mAr;
      ctlPkg::diagReadArx: return mArx;
      ctlPkg::diagReadMq:  return mMq;
      ctlPkg::diagReadPc:  return dataWidth'(mPc);
      ctlPkg::diagReadReg: return dataWidth'(mReg);
      // Strobes are idle between steps
      default:             return '0;
    endcase
  endfunction

  task automatic issueMicroword(input int idx);
    ctlPkg::uinstT        word;
    logic [dataWidth-1:0] mem;
    logic [63:0]          rnd;
    logic [8:0]           status;
    logic                 overlap;
    int                   edges;
    word    = opWord[idx];
    mem     = opData[idx];
    overlap = opFlag[idx] == 2'd2;
    if (opFlag[idx] == 2'd1) begin
      rnd = {$random(seed), $random(seed)};
      mem = rnd[dataWidth-1:0];
    end
    uinst   = word;
    memData = mem;
    uReq    = 1'b1;
    edges   = 0;
    while (!uAck && edges < ackLimit) begin
      nextCycle();
      edges++;
      // Console read sampled on the edge where step is high
      if (overlap && edges == 1) begin
        diagFunc = ctlPkg::diagReadCtl;
        diagData = '0;
        dReq     = 1'b1;
      end
    end
    if (!uAck) begin
      $display("Error: uAck did not rise within %0d cycles of uReq", ackLimit);
      otherErrors++;
      aborted = 1'b1;
    end else begin
      checkValue("uAck latency", dataWidth'(2), dataWidth'(edges));
      predictStep(word, mem, status);
      if (overlap) begin
        checkValue("dAck", dataWidth'(1'b1), dataWidth'(dAck));
        checkValue("readData ctlStatus", dataWidth'(status), readData);
      end
      uReq = 1'b0;
      dReq = 1'b0;
      nextCycle();
      checkValue("uAck", '0, dataWidth'(uAck));
      checkValue("dAck", '0, dataWidth'(dAck));
    end
  endtask

  task automatic consoleAccess(input int idx);
    ctlPkg::uinstT        word;
    ctlPkg::diagFuncT     func;
    logic [dataWidth-1:0] data;
    logic [dataWidth-1:0] expected;
    int                   edges;
    word     = opWord[idx];
    func     = word[6:0];
    data     = opData[idx];
    expected = expectedRead(func);
    diagFunc = func;
    diagData = data;
    dReq     = 1'b1;
    edges    = 0;
    while (!dAck && edges < ackLimit) begin
      nextCycle();
      edges++;
    end
    if (!dAck) begin
      $display("Error: dAck did not rise within %0d cycles of dReq", ackLimit);
      otherErrors++;
      aborted = 1'b1;
    end else begin
      checkValue("dAck latency", dataWidth'(1), dataWidth'(edges));
      checkValue("readData", expected, readData);
      if (opFlag[idx] == 2'd1) checkValue("readData (file value)", opExpect[idx], readData);
      if (func == ctlPkg::diagLoadReg) mReg = data[3:0];
      if (func == ctlPkg::diagLoadAr) mAr = data;
      dReq = 1'b0;
      nextCycle();
      checkValue("dAck", '0, dataWidth'(dAck));
      checkValue("readData after dAck", '0, readData);
      checkValue("memReset", dataWidth'(mReg[3]), dataWidth'(memReset));
      checkValue("channelClkStop", dataWidth'(mReg[2]), dataWidth'(channelClkStop));
    end
  endtask

  initial begin : mainFlow
    valueErrors = 0;
    otherErrors = 0;
    aborted     = 1'b0;
    opsLoaded   = 1'b0;
    seed        = 32'ha433_cea0;
    rstN        = 1'b0;
    uReq        = 1'b0;
    uinst       = '0;
    memData     = '0;
    dReq        = 1'b0;
    diagFunc    = '0;
    diagData    = '0;
    mAr         = '0;
    mArx        = '0;
    mMq         = '0;
    mPc         = '0;
    mReg        = '0;
    readStimulus();

    repeat (16) @(posedge CTL);
    #1;
    rstN = 1'b1;
    checkValue("uAck", '0, dataWidth'(uAck));
    checkValue("dAck", '0, dataWidth'(dAck));
    checkValue("memReset", '0, dataWidth'(memReset));
    checkValue("channelClkStop", '0, dataWidth'(channelClkStop));
    checkValue("readData", '0, readData);

    for (int i = 0; i < opKind.size() && !aborted; i++) begin
      if (opKind[i] == "U") issueMicroword(i);
      else consoleAccess(i);
    end
    finishRun();
  end

  // Each operation needs a handful of cycles, 20 leaves plenty of margin
  initial begin : watchdog
    wait (opsLoaded === 1'b1);
    repeat (opKind.size() * 20 + 16) @(posedge CTL);
    $display("Error: run did not finish in the time allowed for %0d operations", opKind.size());
    otherErrors++;
    finishRun();
  end

endmodule

/* testbench/stimulus_input.txt */
# U disp spec cond arSel arxSel mqLoad magic memData mode (hex; mode 1 random memData, 2 ctl read)
# D func(octal) diagData expectedRead checkExpected (hex; checkExpected 1 compares the file value)
U 0 0 0 1 1 0 000 123456789 0
D 100 0 0 0
D 101 0 0 0
U 0 0 0 1 0 0 000 0000ABCDE 0
D 100 0 0 0
D 101 0 0 0
U 0 0 1 1 0 0 000 3FFFF0000 0
D 100 0 0 0
U 0 0 2 1 0 0 000 000012345 0
D 100 0 0 0
U 0 0 3 1 0 0 000 FFFFFFFFF 0
D 100 0 0 0
U 0 0 0 1 1 0 000 7FFF20000 0
U 3 0 0 0 0 0 000 0 0
D 100 0 0 0
U 0 0 4 0 0 0 000 0 0
D 101 0 0 0
U 0 0 0 1 1 0 000 00003FFFF 0
U 0 0 0 2 0 0 000 0 0
D 100 0 0 0
U 0 0 0 1 0 0 000 00003FFFF 0
U 0 1 0 2 0 0 000 0 0
D 100 0 0 0
U 0 0 0 1 1 0 000 000000001 0
U 0 2 0 2 0 0 000 0 0
D 100 0 0 0
U 0 0 0 1 1 1 000 987654321 0
D 102 0 0 0
U 1 0 0 0 0 0 000 0 0
D 102 0 0 0
U 0 3 0 0 0 0 000 0 0
D 102 0 0 0
U 0 5 0 0 0 0 040 0 0
D 102 0 0 0
U 0 0 5 0 0 0 1A0 0 0
D 100 0 0 0
U 0 0 0 1 0 0 000 0000C3A5F 0
U 0 4 0 0 0 0 000 0 0
D 103 0 0 0
D 076 00000000C 0 0
D 105 0 00000000C 1
D 177 2468ACE13 0 0
D 100 0 2468ACE13 1
U 1 5 0 1 1 0 060 13579BDF0 2
D 104 0 0 1
U 0 0 0 1 1 0 000 0 1
U 0 0 0 2 3 1 000 0 1
D 100 0 0 0
D 101 0 0 0
D 102 0 0 0
D 076 0 0 0
D 105 0 0 1

/* project.f */
design/ctlPkg.sv
design/uinstIssue.sv
design/uinstDecode.sv
design/arDatapath.sv
design/diagResult.sv
design/ctlSubsystem.sv
testbench/ctlSubsystemTb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ctlSubsystemTb -f project.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
